//--- mac_mem_top.f
hdl/mac_mem_pkg.sv
hdl/bus_slot_sequencer.sv
hdl/reset_sequencer.sv
hdl/rom_download_mapper.sv
hdl/floppy_image_tracker.sv
hdl/sdram_request_mux.sv
hdl/mac_mem_top.sv
sim/mac_mem_top_sva.sv
sim/tb_mac_mem_top.sv

//--- Bender.yml
package:
  name: mac_mem_top

sources:
  - hdl/mac_mem_pkg.sv
  - hdl/bus_slot_sequencer.sv
  - hdl/reset_sequencer.sv
  - hdl/rom_download_mapper.sv
  - hdl/floppy_image_tracker.sv
  - hdl/sdram_request_mux.sv
  - hdl/mac_mem_top.sv
  - target: simulation
    files:
      - sim/mac_mem_top_sva.sv
      - sim/tb_mac_mem_top.sv

//--- sim/mac_mem_testdata.txt
// kind 1 word: index byte_addr data exp_mem_addr exp_wdata | 2 end: index words exp_ins exp_ds 0
// kind 3 eject: mask exp_ins exp_ds 0 0 | 4 cpu: op addr word exp_addr exp_data | 5 act: mask | 0 stop
1 0 10 1234 200008 3412
1 0 7fffe a55a 23ffff 5aa5
2 0 40000 0 0 0
1 40 100 beef 240080 efbe
2 40 81 0 0 0
1 3 80002 0102 200001 0201
2 3 0 0 0 0
1 1 4 cafe 280002 feca
1 1 c7ffe 00ff 2e3fff ff00
2 1 64000 1 1 0
1 2 2 1357 300001 5713
2 2 32000 3 1 0
2 2 1234 1 1 0
2 2 32000 3 1 0
3 1 2 0 0 0
3 2 0 0 0 0
4 0 12346 4e71 2491a3 4e71
4 1 3ffffe 6000 1fffff 6000
4 2 124 2468 92 2468
4 3 201 ab12 200100 1212
4 3 200 ab12 200100 abab
4 4 40 0 300001 ffff
5 1 0 0 0 0
0 0 0 0 0 0

//--- sim/tb_mac_mem_top.sv
// Testbench for the memory glue top level with file-driven vectors, SDRAM write model and checks
`timescale 1ns/10ps
`default_nettype none

module tb_mac_mem_top;

	localparam int clk_div    = 4;
	localparam int reset_hold = 16;
	localparam int act_hold   = 64;
	localparam int max_vec    = 64;

	logic                 clk_sys;
	logic                 rst;
	logic                 pll_locked, reset_req, cpu_reset_n, mem_4mb_req;
	mac_mem_pkg::model_t  model_req;
	mac_mem_pkg::model_t  cfg_model;
	logic                 ioctl_download, ioctl_wr;
	logic [7:0]           ioctl_index;
	logic [24:0]          ioctl_addr;
	logic [15:0]          ioctl_data;
	logic [1:0]           disk_eject, disk_act, disk_ack;
	logic                 rom_oe_n, ram_oe_n, ram_we_n, uds_n, lds_n;
	logic [21:0]          memory_addr;
	logic [15:0]          memory_dout, mem_rdata;
	wire  [15:0]          memory_din, mem_wdata;
	wire  [24:0]          mem_addr;
	wire  [1:0]           mem_ds, disk_inserted, disk_double_sided;
	wire                  ioctl_wait, mem_we, mem_oe, sys_reset_n, cfg_mem_4mb, led_user;

	logic [31:0]          vec [0:6*max_vec-1];
	int                   errors = 0;
	int                   cycles = 0;
	int                   cycle_limit = 0;
	int                   wr_bursts = 0;
	logic                 we_prev = 1'b0;
	logic [24:0]          last_wr_addr;
	logic [15:0]          last_wr_data;
	logic [1:0]           last_wr_ds;
	logic [15:0]          mem_store [logic [24:0]];

	mac_mem_top #(.CLK_DIV(clk_div), .RESET_HOLD(reset_hold), .ACT_HOLD(act_hold)) dut (
		.clk_sys(clk_sys), .rst(rst), .pll_locked(pll_locked), .reset_req(reset_req),
		.cpu_reset_n(cpu_reset_n), .mem_4mb_req(mem_4mb_req), .model_req(model_req),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wait(ioctl_wait),
		.disk_eject(disk_eject), .disk_act(disk_act), .rom_oe_n(rom_oe_n),
		.ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n), .uds_n(uds_n), .lds_n(lds_n),
		.memory_addr(memory_addr), .memory_dout(memory_dout), .disk_ack(disk_ack),
		.memory_din(memory_din), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ds(mem_ds), .mem_we(mem_we), .mem_oe(mem_oe), .mem_rdata(mem_rdata),
		.sys_reset_n(sys_reset_n), .cfg_mem_4mb(cfg_mem_4mb), .cfg_model(cfg_model),
		.disk_inserted(disk_inserted), .disk_double_sided(disk_double_sided),
		.led_user(led_user)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// SDRAM model, a write slot keeps mem_we high for several clocks
	always @(posedge clk_sys) begin
		if (mem_we) begin
			mem_store[mem_addr] = mem_wdata;
			if (!we_prev) begin
				wr_bursts++;
				last_wr_addr = mem_addr;
				last_wr_data = mem_wdata;
				last_wr_ds = mem_ds;
			end
		end
		we_prev = mem_we;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic mismatch(input string msg);
		errors++;
		$display("MISMATCH at %0d ns: %s", $time, msg);
	endtask

	task automatic failure(input string msg);
		errors++;
		$display("Failure at %0d ns: %s", $time, msg);
	endtask

	// ======================================================================
	// Host download word, one SDRAM write before the host is released
	// ======================================================================

	task automatic download_word(input logic [31:0] idx, baddr, data, exp_addr, exp_data);
		int cyc;
		int n0;
		if (!ioctl_download) begin
			ioctl_index = idx[7:0];
			ioctl_download = 1'b1;
			step();
		end
		if (led_user !== 1'b1)
			mismatch("led_user low while a download runs");
		cyc = 0;
		while (ioctl_wait && cyc < 40) begin
			step();
			cyc++;
		end
		n0 = wr_bursts;
		ioctl_index = idx[7:0];
		ioctl_addr = baddr[24:0];
		ioctl_data = data[15:0];
		ioctl_wr = 1'b1;
		step();
		ioctl_wr = 1'b0;
		cyc = 0;
		while (ioctl_wait && cyc < 40) begin
			step();
			cyc++;
		end
		if (ioctl_wait) begin
			failure($sformatf("ioctl_wait stuck high for index %0d", idx));
		end else begin
			if (wr_bursts - n0 != 1)
				mismatch($sformatf("index %0d: %0d writes for one word", idx, wr_bursts - n0));
			if (last_wr_addr !== exp_addr[24:0] || last_wr_data !== exp_data[15:0])
				mismatch($sformatf("index %0d: wrote %h at %h, expected %h at %h", idx,
					last_wr_data, last_wr_addr, exp_data[15:0], exp_addr[24:0]));
			if (last_wr_ds !== 2'b11)
				mismatch($sformatf("index %0d: byte strobes %b on the download write", idx,
					last_wr_ds));
			if (mem_store[exp_addr[24:0]] !== exp_data[15:0])
				mismatch($sformatf("memory word at %h not stored", exp_addr[24:0]));
		end
	endtask

	// Host image end, the address bus carries the word count
	task automatic download_end(input logic [31:0] idx, words, exp_ins, exp_ds);
		if (!ioctl_download) begin
			ioctl_index = idx[7:0];
			ioctl_download = 1'b1;
			step();
		end
		ioctl_index = idx[7:0];
		ioctl_addr = 25'(words << 1);
		step();
		ioctl_download = 1'b0;
		step();
		if (disk_inserted !== exp_ins[1:0] || disk_double_sided !== exp_ds[1:0])
			mismatch($sformatf("end index %0d count %0d: inserted %b ds %b, expected %b %b",
				idx, words, disk_inserted, disk_double_sided, exp_ins[1:0], exp_ds[1:0]));
	endtask

	// ======================================================================
	// CPU side access, op 0 ROM, 1 RAM read, 2 RAM write, 3 disk, 4 download slot
	// ======================================================================

	task automatic cpu_access(input logic [31:0] op, addr, word, exp_addr, exp_data);
		int cyc;
		logic [1:0] exp_ds;
		logic exp_we;
		logic exp_oe;
		cyc = 0;
		memory_addr = addr[21:0];
		mem_rdata = word[15:0];
		memory_dout = word[15:0];
		uds_n = 1'b0;
		// RAM write stores the upper byte only
		lds_n = (op == 2);
		exp_ds = (op == 2) ? 2'b10 : 2'b11;
		// Reads enable SDRAM output, a download slot keeps it off
		exp_we = (op == 2);
		exp_oe = (op <= 1 || op == 3);
		case (op)
			0: rom_oe_n = 1'b0;
			1: ram_oe_n = 1'b0;
			2: ram_we_n = 1'b0;
			3: disk_ack = 2'b01;
			default: begin
				// CPU read lands inside a host I/O slot
				ioctl_index = 8'd0;
				ioctl_download = 1'b1;
				ram_oe_n = 1'b0;
				while (!dut.io_slot && cyc < 4 * clk_div) begin
					step();
					cyc++;
				end
			end
		endcase
		#1;
		if (mem_addr !== exp_addr[24:0])
			mismatch($sformatf("op %0d: mem_addr %h, expected %h", op, mem_addr, exp_addr[24:0]));
		if (mem_we !== exp_we || mem_oe !== exp_oe || mem_ds !== exp_ds)
			mismatch($sformatf("op %0d: we %b oe %b ds %b, expected %b %b %b", op, mem_we,
				mem_oe, mem_ds, exp_we, exp_oe, exp_ds));
		if (op == 2) begin
			if (mem_wdata !== exp_data[15:0])
				mismatch($sformatf("RAM write: data %h, expected %h", mem_wdata,
					exp_data[15:0]));
		end else if (memory_din !== exp_data[15:0]) begin
			mismatch($sformatf("op %0d: memory_din %h, expected %h", op, memory_din,
				exp_data[15:0]));
		end
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		disk_ack = 2'b00;
		ioctl_download = 1'b0;
		step();
	endtask

	initial begin
		int i;
		int nvec;
		int cyc;
		int budget;
		logic [31:0] f [1:5];
		for (i = 0; i < 6 * max_vec; i++)
			vec[i] = '0;
		$readmemh("sim/mac_mem_testdata.txt", vec);
		rst = 1'b1;
		pll_locked = 1'b1;
		reset_req = 1'b0;
		cpu_reset_n = 1'b1;
		mem_4mb_req = 1'b1;
		model_req = mac_mem_pkg::model_se;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_data = '0;
		disk_eject = 2'b00;
		disk_act = 2'b00;
		disk_ack = 2'b00;
		rom_oe_n = 1'b1;
		ram_oe_n = 1'b1;
		ram_we_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		memory_addr = '0;
		memory_dout = '0;
		mem_rdata = '0;

		// Budget per line kind, then doubled for the limit
		budget = reset_hold * clk_div + 200;
		nvec = 0;
		while (nvec < max_vec && vec[6*nvec] != 0) begin
			case (vec[6*nvec])
				1: budget += 40;
				4: budget += 4 * clk_div + 8;
				5: budget += act_hold + 8;
				default: budget += 8;
			endcase
			nvec++;
		end
		cycle_limit = 2 * budget;

		repeat (2) @(posedge clk_sys);
		#1;
		rst = 1'b0;
		if (sys_reset_n !== 1'b0 || mem_we !== 1'b0 || mem_oe !== 1'b0)
			mismatch("sys_reset_n, mem_we or mem_oe not low after reset");
		cyc = 0;
		while (!sys_reset_n && cyc < (reset_hold + 2) * clk_div) begin
			step();
			cyc++;
		end
		if (!sys_reset_n)
			failure("sys_reset_n did not rise after the reset hold");
		if (cfg_model !== mac_mem_pkg::model_se || cfg_mem_4mb !== 1'b1)
			mismatch($sformatf("config model %0d 4mb %b latched", cfg_model, cfg_mem_4mb));

		for (i = 0; i < nvec; i++) begin
			for (int k = 1; k <= 5; k++)
				f[k] = vec[6*i+k];
			case (vec[6*i])
				1: download_word(f[1], f[2], f[3], f[4], f[5]);
				2: download_end(f[1], f[2], f[3], f[4]);
				3: begin
					disk_eject = f[1][1:0];
					step();
					disk_eject = 2'b00;
					if (disk_inserted !== f[2][1:0] || disk_double_sided !== f[3][1:0])
						mismatch($sformatf("eject %b: inserted %b ds %b", f[1][1:0],
							disk_inserted, disk_double_sided));
				end
				4: cpu_access(f[1], f[2], f[3], f[4], f[5]);
				default: begin
					// Activity pulse holds the LED for a while
					disk_act = f[1][1:0];
					step();
					disk_act = 2'b00;
					if (led_user !== 1'b1)
						mismatch("led_user low after disk_act");
					cyc = 0;
					while (led_user && cyc < act_hold + 2) begin
						step();
						cyc++;
					end
					if (led_user)
						failure("led_user still high after the activity hold");
					else if (cyc < act_hold - 1)
						mismatch($sformatf("led_user fell after only %0d cycles of hold", cyc));
				end
			endcase
		end

		repeat (4) step();
		$display("Summary: %0d vectors, %0d errors, %0d assertion failures", nvec, errors,
			dut.u_sva.assert_fails);
		if (errors == 0 && dut.u_sva.assert_fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/mac_mem_top_sva.sv
// Bound assertions on the host write handshake, download write gating and reset
`timescale 1ns/10ps
`default_nettype none

module mac_mem_top_sva (
	input wire clk_sys,
	input wire rst,
	input wire ioctl_download,
	input wire ioctl_wait,
	input wire mem_we,
	input wire sys_reset_n
);

	// Number of failed assertions so far
	int assert_fails = 0;

	// Set once the stalled word reached SDRAM, cleared while the host is free
	logic seen_we;

	always @(posedge clk_sys) begin
		if (rst || !ioctl_wait)
			seen_we <= 1'b0;
		else if (mem_we)
			seen_we <= 1'b1;
	end

	// Host is released only after its word was written
	a_wait_after_write: assert property (@(posedge clk_sys) disable iff (rst)
		$fell(ioctl_wait) |-> seen_we)
		else begin
			assert_fails++;
			$error("ioctl_wait fell before the download word was written");
		end

	// No SDRAM write while the host port is idle during a download
	a_no_idle_write: assert property (@(posedge clk_sys) disable iff (rst)
		(ioctl_download && !ioctl_wait) |-> !mem_we)
		else begin
			assert_fails++;
			$error("mem_we high with a download active and no word pending");
		end

	// System reset follows rst within one cycle
	a_reset_follows: assert property (@(posedge clk_sys) rst |=> !sys_reset_n)
		else begin
			assert_fails++;
			$error("sys_reset_n high in the cycle after rst");
		end

endmodule

bind mac_mem_top mac_mem_top_sva u_sva (
	.clk_sys(clk_sys), .rst(rst), .ioctl_download(ioctl_download),
	.ioctl_wait(ioctl_wait), .mem_we(mem_we), .sys_reset_n(sys_reset_n)
);

`default_nettype wire

//--- hdl/mac_mem_top.sv
// Memory glue top level with slot sequencer, reset sequencer, download mapper, floppy tracker and SDRAM mux
`timescale 1ns/10ps
`default_nettype none

module mac_mem_top #(
	parameter int CLK_DIV    = 4,
	parameter int RESET_HOLD = 65535,
	parameter int ACT_HOLD   = 500000
) (
	input  wire                                 clk_sys,
	input  wire                                 rst,
	input  wire                                 pll_locked,
	input  wire                                 reset_req,
	input  wire                                 cpu_reset_n,
	input  wire                                 mem_4mb_req,
	input  mac_mem_pkg::model_t                 model_req,
	// Host write port
	input  wire                                 ioctl_download,
	input  wire  [7:0]                          ioctl_index,
	input  wire                                 ioctl_wr,
	input  wire  [mac_mem_pkg::host_aw-1:0]     ioctl_addr,
	input  wire  [mac_mem_pkg::data_w-1:0]      ioctl_data,
	output wire                                 ioctl_wait,
	// Floppy controller
	input  wire  [1:0]                          disk_eject,
	input  wire  [1:0]                          disk_act,
	// CPU side
	input  wire                                 rom_oe_n,
	input  wire                                 ram_oe_n,
	input  wire                                 ram_we_n,
	input  wire                                 uds_n,
	input  wire                                 lds_n,
	input  wire  [21:0]                         memory_addr,
	input  wire  [mac_mem_pkg::data_w-1:0]      memory_dout,
	input  wire  [1:0]                          disk_ack,
	output wire  [mac_mem_pkg::data_w-1:0]      memory_din,
	// SDRAM word port
	output wire  [mac_mem_pkg::sdram_aw-1:0]    mem_addr,
	output wire  [mac_mem_pkg::data_w-1:0]      mem_wdata,
	output wire  [1:0]                          mem_ds,
	output wire                                 mem_we,
	output wire                                 mem_oe,
	input  wire  [mac_mem_pkg::data_w-1:0]      mem_rdata,
	// Status
	output wire                                 sys_reset_n,
	output wire                                 cfg_mem_4mb,
	output mac_mem_pkg::model_t                 cfg_model,
	output wire  [1:0]                          disk_inserted,
	output wire  [1:0]                          disk_double_sided,
	output wire                                 led_user
);

	wire                                clk8_en;
	wire                                io_slot;
	wire [mac_mem_pkg::dio_aw-1:0]      dio_addr;
	wire [mac_mem_pkg::data_w-1:0]      dio_data;
	wire                                dio_write;
	wire [mac_mem_pkg::host_aw-2:0]     dio_word_addr;

	// Slot timing, only the I/O flag leaves this block
	bus_slot_sequencer #(.CLK_DIV(CLK_DIV)) u_slot (
		.clk_sys(clk_sys), .rst(rst), .clk8_en(clk8_en), .slot(), .io_slot(io_slot)
	);

	reset_sequencer #(.RESET_HOLD(RESET_HOLD)) u_reset (
		.clk_sys(clk_sys), .rst(rst), .clk8_en(clk8_en), .pll_locked(pll_locked),
		.reset_req(reset_req), .cpu_reset_n(cpu_reset_n), .mem_4mb_req(mem_4mb_req),
		.model_req(model_req), .sys_reset_n(sys_reset_n), .cfg_mem_4mb(cfg_mem_4mb),
		.cfg_model(cfg_model)
	);

	rom_download_mapper u_mapper (
		.clk_sys(clk_sys), .rst(rst), .ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .io_slot(io_slot),
		.ioctl_wait(ioctl_wait), .dio_addr(dio_addr), .dio_data(dio_data),
		.dio_write(dio_write), .dio_word_addr(dio_word_addr)
	);

	floppy_image_tracker #(.ACT_HOLD(ACT_HOLD)) u_floppy (
		.clk_sys(clk_sys), .rst(rst), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .dio_word_addr(dio_word_addr), .disk_eject(disk_eject),
		.disk_act(disk_act), .disk_inserted(disk_inserted),
		.disk_double_sided(disk_double_sided), .led_user(led_user)
	);

	sdram_request_mux u_mux (
		.ioctl_download(ioctl_download), .io_slot(io_slot), .dio_addr(dio_addr),
		.dio_data(dio_data), .dio_write(dio_write), .cfg_model(cfg_model),
		.rom_oe_n(rom_oe_n), .ram_oe_n(ram_oe_n), .ram_we_n(ram_we_n), .uds_n(uds_n),
		.lds_n(lds_n), .memory_addr(memory_addr), .memory_dout(memory_dout),
		.disk_ack(disk_ack), .mem_rdata(mem_rdata), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ds(mem_ds), .mem_we(mem_we), .mem_oe(mem_oe),
		.memory_din(memory_din)
	);

endmodule

`default_nettype wire

//--- hdl/sdram_request_mux.sv
// SDRAM request selection between download, ROM, RAM and disk reads, and CPU read data shaping
`timescale 1ns/10ps
`default_nettype none

module sdram_request_mux (
	input  wire                                 ioctl_download,
	input  wire                                 io_slot,
	input  wire  [mac_mem_pkg::dio_aw-1:0]      dio_addr,
	input  wire  [mac_mem_pkg::data_w-1:0]      dio_data,
	input  wire                                 dio_write,
	input  mac_mem_pkg::model_t                 cfg_model,
	input  wire                                 rom_oe_n,
	input  wire                                 ram_oe_n,
	input  wire                                 ram_we_n,
	input  wire                                 uds_n,
	input  wire                                 lds_n,
	input  wire  [21:0]                         memory_addr,
	input  wire  [mac_mem_pkg::data_w-1:0]      memory_dout,
	input  wire  [1:0]                          disk_ack,
	input  wire  [mac_mem_pkg::data_w-1:0]      mem_rdata,
	output logic [mac_mem_pkg::sdram_aw-1:0]    mem_addr,
	output logic [mac_mem_pkg::data_w-1:0]      mem_wdata,
	output logic [1:0]                          mem_ds,
	output logic                                mem_we,
	output logic                                mem_oe,
	output logic [mac_mem_pkg::data_w-1:0]      memory_din
);

	logic                               download_cycle;
	logic                               disk_rd;
	logic [mac_mem_pkg::data_w-1:0]     disk_byte;

	// Host owns the I/O slot only while a download runs
	assign download_cycle = ioctl_download & io_slot;
	assign disk_rd        = |disk_ack;

	// ======================================================================
	// Request toward SDRAM
	// ======================================================================

	always_comb begin
		if (download_cycle) begin
			mem_addr  = {mac_mem_pkg::rom_region, dio_addr};
			mem_wdata = dio_data;
			mem_ds    = 2'b11;
			mem_we    = dio_write;
			mem_oe    = 1'b0;
		end else begin
			// ROM in upper region, model bit 0 selects the 256K layout
			// RAM and disk images sit in the lower half, disk flag on top
			if (!rom_oe_n)
				mem_addr = {mac_mem_pkg::rom_region, 2'b00, cfg_model[0], memory_addr[18:1]};
			else
				mem_addr = {3'b000, disk_rd, memory_addr[21:1]};
			mem_wdata = memory_dout;
			mem_ds    = {~uds_n, ~lds_n};
			mem_we    = ~ram_we_n;
			mem_oe    = ~ram_oe_n | ~rom_oe_n | disk_rd;
		end
	end

	// ======================================================================
	// Read data back to the CPU side
	// ======================================================================

	// Disk reader is byte wide, address bit 0 picks the byte
	assign disk_byte = memory_addr[0] ? {mem_rdata[7:0], mem_rdata[7:0]}
	                                  : {mem_rdata[15:8], mem_rdata[15:8]};

	assign memory_din = download_cycle ? mac_mem_pkg::download_fill :
	                    disk_rd        ? disk_byte : mem_rdata;

endmodule

`default_nettype wire

//--- hdl/floppy_image_tracker.sv
// Floppy image size check at download end, eject handling and disk activity LED stretch
`timescale 1ns/10ps
`default_nettype none

module floppy_image_tracker #(
	parameter int ACT_HOLD = 500000
) (
	input  wire                               clk_sys,
	input  wire                               rst,
	input  wire                               ioctl_download,
	input  wire  [7:0]                        ioctl_index,
	input  wire  [mac_mem_pkg::host_aw-2:0]   dio_word_addr,
	input  wire  [1:0]                        disk_eject,
	input  wire  [1:0]                        disk_act,
	output logic [1:0]                        disk_inserted,
	output logic [1:0]                        disk_double_sided,
	output logic                              led_user
);

	// Activity counter width, at least one bit
	localparam int act_w = (ACT_HOLD > 0) ? $clog2(ACT_HOLD + 1) : 1;

	logic [1:0]        dsk_ds;
	logic [1:0]        dsk_ss;
	logic              download_d;
	logic              download_end;
	logic [act_w-1:0]  act_cnt;

	// Falling edge of the download strobe
	always_ff @(posedge clk_sys) begin
		if (rst)
			download_d <= 1'b0;
		else
			download_d <= ioctl_download;
	end

	assign download_end = download_d & ~ioctl_download;

	// ======================================================================
	// Per-drive image state
	// ======================================================================

	for (genvar d = 0; d < 2; d++) begin : g_drive
		// Drive 0 takes index 1, drive 1 takes index 2
		localparam logic [7:0] drv_index =
			(d == 0) ? mac_mem_pkg::idx_floppy_int : mac_mem_pkg::idx_floppy_ext;

		always_ff @(posedge clk_sys) begin
			if (rst) begin
				dsk_ds[d] <= 1'b0;
				dsk_ss[d] <= 1'b0;
			end else begin
				// Word count decides the disk format, unknown sizes are rejected
				if (download_end && ioctl_index == drv_index) begin
					dsk_ds[d] <= (dio_word_addr == mac_mem_pkg::dsk_words_ds);
					dsk_ss[d] <= (dio_word_addr == mac_mem_pkg::dsk_words_ss);
				end
				// Eject from the OS wins over a finishing download
				if (disk_eject[d]) begin
					dsk_ds[d] <= 1'b0;
					dsk_ss[d] <= 1'b0;
				end
			end
		end
	end

	assign disk_inserted     = dsk_ds | dsk_ss;
	assign disk_double_sided = dsk_ds;

	// ======================================================================
	// Activity LED
	// ======================================================================

	// Reload on every access so a busy drive keeps the LED on
	always_ff @(posedge clk_sys) begin
		if (rst)
			act_cnt <= '0;
		else if (|disk_act)
			act_cnt <= act_w'(ACT_HOLD);
		else if (act_cnt != '0)
			act_cnt <= act_cnt - 1'b1;
	end

	assign led_user = ioctl_download | (act_cnt != '0);

endmodule

`default_nettype wire

//--- hdl/rom_download_mapper.sv
// Host write capture with byte swap, download address map and ioctl_wait pacing
`timescale 1ns/10ps
`default_nettype none

module rom_download_mapper (
	input  wire                                 clk_sys,
	input  wire                                 rst,
	input  wire                                 ioctl_wr,
	input  wire  [7:0]                          ioctl_index,
	input  wire  [mac_mem_pkg::host_aw-1:0]     ioctl_addr,
	input  wire  [mac_mem_pkg::data_w-1:0]      ioctl_data,
	input  wire                                 io_slot,
	output logic                                ioctl_wait,
	output logic [mac_mem_pkg::dio_aw-1:0]      dio_addr,
	output logic [mac_mem_pkg::data_w-1:0]      dio_data,
	output logic                                dio_write,
	output logic [mac_mem_pkg::host_aw-2:0]     dio_word_addr
);

	logic [mac_mem_pkg::dio_aw-1:0]  map_addr;
	logic                            accept;
	logic                            io_slot_d;

	// Host counts bytes, SDRAM counts words
	assign dio_word_addr = ioctl_addr[mac_mem_pkg::host_aw-1:1];

	// Host may only write while not stalled
	assign accept = ioctl_wr & ~ioctl_wait;

	// ======================================================================
	// Address map
	// ======================================================================

	// Images sit above the OS ROM in the upper region
	// Index 1 at word 0x80000, index 2 at word 0x100000
	always_comb begin
		if (ioctl_index == mac_mem_pkg::idx_mac2_rom) begin
			// Mac II ROM, 256K at offset 0
			map_addr = {3'b000, dio_word_addr[17:0]};
		end else if (ioctl_index[1:0] != 2'b00) begin
			map_addr = {ioctl_index[1:0], dio_word_addr[18:0]};
		end else begin
			// Plain ROM, index bit 6 picks the alternate bank
			map_addr = {2'b00, ioctl_index[6], dio_word_addr[17:0]};
		end
	end

	// Payload, loaded only on an accepted write
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			// Host sends little-endian words, 68k wants big-endian
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			dio_addr <= map_addr;
		end
	end

	// ======================================================================
	// Handshake with the I/O slot
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
			io_slot_d  <= 1'b0;
		end else begin
			io_slot_d <= io_slot;

			// Write flag only moves between I/O slots
			// so a slot sees it either set throughout or not at all
			if (!io_slot)
				dio_write <= ioctl_wait;

			if (accept)
				ioctl_wait <= 1'b1;

			// Slot just ended with the word written, free the host
			if (io_slot_d && !io_slot && dio_write)
				ioctl_wait <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/reset_sequencer.sv
// Reset source merge, stretched system reset and configuration latch
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer #(
	parameter int RESET_HOLD = 65535
) (
	input  wire                  clk_sys,
	input  wire                  rst,
	input  wire                  clk8_en,
	input  wire                  pll_locked,
	input  wire                  reset_req,
	input  wire                  cpu_reset_n,
	input  wire                  mem_4mb_req,
	input  mac_mem_pkg::model_t  model_req,
	output logic                 sys_reset_n,
	output logic                 cfg_mem_4mb,
	output mac_mem_pkg::model_t  cfg_model
);

	// Hold counter width, at least one bit
	localparam int hold_w = (RESET_HOLD > 0) ? $clog2(RESET_HOLD + 1) : 1;

	logic [hold_w-1:0]  hold_cnt;
	logic               src_active;

	// Sources other than rst, which acts on every clk_sys edge
	// CPU reset instruction also restarts the machine
	assign src_active = ~pll_locked | reset_req | ~cpu_reset_n;

	// ======================================================================
	// Countdown and configuration latch
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hold_cnt    <= hold_w'(RESET_HOLD);
			sys_reset_n <= 1'b0;
			cfg_mem_4mb <= 1'b0;
			cfg_model   <= mac_mem_pkg::model_plus;
		end else if (clk8_en) begin
			if (src_active) begin
				// Reload and keep the machine in reset
				hold_cnt    <= hold_w'(RESET_HOLD);
				sys_reset_n <= 1'b0;
			end else if (hold_cnt != '0) begin
				hold_cnt    <= hold_cnt - 1'b1;
				// Memory size and model only change under reset
				cfg_mem_4mb <= mem_4mb_req;
				cfg_model   <= model_req;
			end else begin
				// Count expired, release
				sys_reset_n <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/bus_slot_sequencer.sv
// 8 MHz enable divider and four-slot bus rotation with registered I/O slot flag
`timescale 1ns/10ps
`default_nettype none

module bus_slot_sequencer #(
	parameter int CLK_DIV = 4
) (
	input  wire                  clk_sys,
	input  wire                  rst,
	output logic                 clk8_en,
	output mac_mem_pkg::slot_t   slot,
	output logic                 io_slot
);

	// Divider width, at least one bit
	localparam int div_w = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [div_w-1:0]     div_cnt;
	mac_mem_pkg::slot_t   slot_next;

	// Next slot in the rotation, wraps cpu_b back to video
	assign slot_next = mac_mem_pkg::slot_t'(slot + 2'd1);

	// Divider, enable is one clk_sys wide
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_cnt <= '0;
			clk8_en <= 1'b0;
		end else begin
			clk8_en <= (div_cnt == div_w'(CLK_DIV - 1));
			if (div_cnt == div_w'(CLK_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	// Rotation steps once per 8 MHz period
	// I/O flag loads together with the slot so both change on the same edge
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			slot    <= mac_mem_pkg::slot_video;
			io_slot <= 1'b0;
		end else if (clk8_en) begin
			slot    <= slot_next;
			io_slot <= (slot_next == mac_mem_pkg::slot_io);
		end
	end

endmodule

`default_nettype wire

//--- hdl/mac_mem_pkg.sv
// Shared widths, download indices, floppy image sizes, SDRAM region prefix and bus types
`default_nettype none

package mac_mem_pkg;

	// ======================================================================
	// Bus and address widths
	// ======================================================================

	// SDRAM and CPU data word
	localparam int data_w = 16;
	// SDRAM word address
	localparam int sdram_aw = 25;
	// Host byte address on the write port
	localparam int host_aw = 25;
	// Mapped download word address, below the region prefix
	localparam int dio_aw = 21;

	// ======================================================================
	// Download indices and image sizes
	// ======================================================================

	// Internal floppy, external floppy, Mac II ROM
	localparam logic [7:0] idx_floppy_int = 8'd1;
	localparam logic [7:0] idx_floppy_ext = 8'd2;
	localparam logic [7:0] idx_mac2_rom = 8'd3;

	// Image lengths in words, 800K and 400K disks
	localparam logic [host_aw-2:0] dsk_words_ds = 24'd409600;
	localparam logic [host_aw-2:0] dsk_words_ss = 24'd204800;

	// Upper SDRAM area for ROM and disk images
	localparam logic [3:0] rom_region = 4'b0001;

	// Black screen while the host owns the bus
	localparam logic [data_w-1:0] download_fill = 16'hffff;

	// ======================================================================
	// Bus slot and machine types
	// ======================================================================

	// Four-slot rotation, one slot per 8 MHz period
	typedef enum logic [1:0] {
		slot_video = 2'd0,
		slot_cpu_a = 2'd1,
		slot_io    = 2'd2,
		slot_cpu_b = 2'd3
	} slot_t;

	// Bit 0 picks the 256K ROM layout
	typedef enum logic [1:0] {
		model_plus = 2'd0,
		model_se   = 2'd1,
		model_mac2 = 2'd2
	} model_t;

endpackage

`default_nettype wire
